//--- flist.f
common/keypad_pkg.sv
keypad/keypad_scanner.sv
keypad/key_decoder.sv
src/digit_accumulator.sv
src/entry_control.sv
src/keypad_entry_top.sv
verif/keypad_entry_assert.sv
verif/keypad_entry_tb.sv

//--- verif/keypad_entry_tb.sv
module keypad_entry_tb;

  localparam int NUM_TESTS = 7;
  // Budget of 12 keys per test at 45 cycles each
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 12 * 45;
  // Keypad layout in reading order, row 0 first
  localparam logic [16*8-1:0] LAYOUT = "123A456B789C*0#D";

  // One table row, key strings are right-justified ASCII with zero padding
  typedef struct packed {
    logic [8*8-1:0] keys;
    logic [4*8-1:0] bp_keys;
    logic [7:0]     ready_dly;
    logic [15:0]    exp_digits;
    logic [2:0]     exp_count;
  } test_t;

  logic                              clk;
  logic                              nRst;
  logic                              enable;
  logic [keypad_pkg::NUM_ROWS-1:0]   read_row;
  logic                              entry_ready;
  logic [keypad_pkg::NUM_COLS-1:0]   scan_col;
  logic                              entry_valid;
  keypad_pkg::entry_t                entry;

  test_t       tests [NUM_TESTS];
  logic [31:0] rng;
  int          err_count;
  int          pass_count;
  int          fail_count;

  keypad_entry_top keypad_entry_top_i (
    .clk         (clk),
    .nRst        (nRst),
    .enable      (enable),
    .read_row    (read_row),
    .entry_ready (entry_ready),
    .scan_col    (scan_col),
    .entry_valid (entry_valid),
    .entry       (entry)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Stop a stuck run, e.g. an entry that never gets presented
  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Run timed out waiting for an entry after %0d cycles", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Hold and release lengths, 6 to 20 cycles
  task automatic draw_cycles(output int n);
    rng = xorshift32(rng);
    n = 6 + int'(rng % 15);
  endtask

  // Row and column index of a key, row -1 for anything off the layout
  function automatic void locate_key(input logic [7:0] k, output int r, output int c);
    r = -1;
    c = 0;
    for (int p = 0; p < 16; p++) begin
      if (LAYOUT[(15-p)*8 +: 8] == k) begin
        r = p / 4;
        c = p % 4;
      end
    end
  endfunction

  // Keypad model, the row answers only while its column is driven
  task automatic press_key(input logic [7:0] k);
    int         r;
    int         c;
    int         hold;
    int         rel;
    logic [3:0] rbits;
    logic [3:0] cbits;
    locate_key(k, r, c);
    draw_cycles(hold);
    draw_cycles(rel);
    // Ghost shorts the two top rows in the first column
    rbits = (r < 0) ? 4'b1100 : (4'b1000 >> r);
    cbits = (r < 0) ? 4'b1000 : (4'b1000 >> c);
    @(negedge clk);
    while (scan_col != cbits)
      @(negedge clk);
    read_row = rbits;
    repeat (hold) @(negedge clk);
    read_row = '0;
    repeat (rel) @(negedge clk);
  endtask

  // Leading zero bytes are padding
  task automatic press_seq(input logic [8*8-1:0] seq);
    for (int i = 7; i >= 0; i--) begin
      if (seq[i*8 +: 8] != 8'h00)
        press_key(seq[i*8 +: 8]);
    end
  endtask

  task automatic check_entry(input logic [15:0] exp_digits, input logic [2:0] exp_count,
                             input string what);
    assert (entry.digits == exp_digits && entry.count == exp_count) else begin
      $display("[ERROR] %0t: %s entry %h count %0d, expected %h count %0d", $time, what,
               entry.digits, entry.count, exp_digits, exp_count);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("Test %s: ok", name);
    end else begin
      fail_count++;
      $display("Test %s: %0d check(s) failed", name, err_count - errs_before);
    end
  endtask

  // Idle after reset, then one full column rotation
  task automatic check_scan();
    int         errs_before;
    logic [3:0] exp_col;
    errs_before = err_count;
    repeat (2) @(negedge clk);
    assert (scan_col == '0 && !entry_valid) else begin
      $display("[ERROR] %0t: scan_col %b entry_valid %b after reset", $time, scan_col,
               entry_valid);
      err_count++;
    end
    enable = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      exp_col = 4'b1000 >> (i % 4);
      assert (scan_col == exp_col) else begin
        $display("[ERROR] %0t: scan_col %b, expected %b", $time, scan_col, exp_col);
        err_count++;
      end
    end
    finish_test("scan", errs_before);
  endtask

  task automatic run_test(input int idx);
    int                 errs_before;
    int                 wait_cycles;
    keypad_pkg::entry_t held;
    errs_before = err_count;
    press_seq(tests[idx].keys);
    // Handshake wait, bounded by the watchdog
    while (!entry_valid)
      @(negedge clk);
    check_entry(tests[idx].exp_digits, tests[idx].exp_count, "presented");
    held = entry;
    if (tests[idx].ready_dly != 0) begin
      // Typed while the entry waits, all of it must be dropped
      press_seq({32'h0, tests[idx].bp_keys});
      rng = xorshift32(rng);
      wait_cycles = int'(tests[idx].ready_dly) + int'(rng % 16);
      for (int i = 0; i < wait_cycles; i++) begin
        @(negedge clk);
        assert (entry_valid && entry == held) else begin
          $display("[ERROR] %0t: entry %h count %0d moved while ready low", $time,
                   entry.digits, entry.count);
          err_count++;
        end
      end
    end
    entry_ready = 1'b1;
    @(negedge clk);
    entry_ready = 1'b0;
    assert (!entry_valid) else begin
      $display("[ERROR] %0t: entry_valid still high after transfer", $time);
      err_count++;
    end
    check_entry(16'h0000, 3'd0, "cleared");
    finish_test($sformatf("%0d", idx), errs_before);
  endtask

  // G is a ghost press, letters must be ignored
  task automatic load_table();
    tests[0] = '{"123#",   "",    8'd0, 16'h0123, 3'd3};
    tests[1] = '{"12345#", "",    8'd0, 16'h1234, 3'd4};
    tests[2] = '{"98*47#", "",    8'd0, 16'h0047, 3'd2};
    tests[3] = '{"A5BG#",  "",    8'd0, 16'h0005, 3'd1};
    tests[4] = '{"#",      "",    8'd0, 16'h0000, 3'd0};
    tests[5] = '{"0D7C#",  "9*#", 8'd5, 16'h0007, 3'd2};
    tests[6] = '{"6#",     "",    8'd0, 16'h0006, 3'd1};
  endtask

  initial begin
    nRst        = 1'b0;
    enable      = 1'b0;
    read_row    = '0;
    entry_ready = 1'b0;
    rng         = 32'h8d6f88e6;
    err_count   = 0;
    pass_count  = 0;
    fail_count  = 0;
    load_table();
    repeat (10) @(negedge clk);
    nRst = 1'b1;
    check_scan();
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    $display("Tests passed: %0d, failed: %0d, check errors: %0d, assertion errors: %0d",
             pass_count, fail_count, err_count,
             keypad_entry_top_i.keypad_entry_assert_i.assert_errors);
    if (fail_count == 0 && err_count == 0 &&
        keypad_entry_top_i.keypad_entry_assert_i.assert_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- verif/keypad_entry_assert.sv
module keypad_entry_assert (
  input logic                             clk,
  input logic                             nRst,
  input logic                             entry_valid,
  input logic                             entry_ready,
  input logic                             key_strobe,
  input logic [keypad_pkg::NUM_COLS-1:0]  scan_col,
  input keypad_pkg::entry_t               entry
);

  // Number of assertion failures so far
  int assert_errors = 0;

  // Offered entry is held until downstream takes it
  hold_a: assert property (@(posedge clk) disable iff (!nRst)
    entry_valid && !entry_ready |=> entry_valid && $stable(entry))
    else begin
      $error("entry dropped or changed while entry_ready was low");
      assert_errors++;
    end

  // Idle or exactly one column driven
  col_a: assert property (@(posedge clk) disable iff (!nRst) $onehot0(scan_col))
    else begin
      $error("scan_col drives more than one column");
      assert_errors++;
    end

  // One strobe per press
  strobe_a: assert property (@(posedge clk) disable iff (!nRst) key_strobe |=> !key_strobe)
    else begin
      $error("key_strobe high on two consecutive cycles");
      assert_errors++;
    end

endmodule

// Top level sees the control outputs and the scanner strobe together
bind keypad_entry_top keypad_entry_assert keypad_entry_assert_i (
  .clk         (clk),
  .nRst        (nRst),
  .entry_valid (entry_valid),
  .entry_ready (entry_ready),
  .key_strobe  (key_strobe),
  .scan_col    (scan_col),
  .entry       (entry)
);

//--- src/keypad_entry_top.sv
module keypad_entry_top (
  input  logic                             clk,
  input  logic                             nRst,
  input  logic                             enable,
  input  logic [keypad_pkg::NUM_ROWS-1:0]  read_row,
  input  logic                             entry_ready,
  output logic [keypad_pkg::NUM_COLS-1:0]  scan_col,
  output logic                             entry_valid,
  output keypad_pkg::entry_t               entry
);

  // Scanner to decoder
  keypad_pkg::key_raw_t key_raw;
  logic                 key_strobe;
  // Decoder to control
  keypad_pkg::key_evt_t key_evt;
  logic                 key_evt_valid;
  // Control to accumulator
  logic                 acc_clear;
  logic                 acc_push;
  keypad_pkg::entry_t   acc_entry;

  keypad_scanner keypad_scanner_i (
    .clk        (clk),
    .nRst       (nRst),
    .enable     (enable),
    .read_row   (read_row),
    .scan_col   (scan_col),
    .key_raw    (key_raw),
    .key_strobe (key_strobe)
  );

  key_decoder key_decoder_i (
    .clk           (clk),
    .nRst          (nRst),
    .key_raw       (key_raw),
    .key_strobe    (key_strobe),
    .key_evt       (key_evt),
    .key_evt_valid (key_evt_valid)
  );

  entry_control entry_control_i (
    .clk           (clk),
    .nRst          (nRst),
    .key_evt       (key_evt),
    .key_evt_valid (key_evt_valid),
    .entry_ready   (entry_ready),
    .acc_clear     (acc_clear),
    .acc_push      (acc_push),
    .entry_valid   (entry_valid)
  );

  // Pushed digit comes straight from the event payload
  digit_accumulator digit_accumulator_i (
    .clk        (clk),
    .nRst       (nRst),
    .acc_clear  (acc_clear),
    .acc_push   (acc_push),
    .push_digit (key_evt.value),
    .acc_entry  (acc_entry)
  );

  assign entry = acc_entry;

endmodule

//--- src/entry_control.sv
module entry_control (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_evt_t  key_evt,
  input  logic                  key_evt_valid,
  input  logic                  entry_ready,
  output logic                  acc_clear,
  output logic                  acc_push,
  output logic                  entry_valid
);

  // COLLECT builds the entry, PRESENT offers it downstream
  typedef enum logic {
    COLLECT = 1'b0,
    PRESENT = 1'b1
  } state_e;

  state_e state;
  state_e state_next;
  logic   is_digit;
  logic   is_clear;
  logic   is_enter;
  logic   xfer;

  // Event decode, only acted on while collecting
  assign is_digit = key_evt_valid && (key_evt.cls == keypad_pkg::KEY_DIGIT);
  assign is_clear = key_evt_valid && (key_evt.cls == keypad_pkg::KEY_CLEAR);
  assign is_enter = key_evt_valid && (key_evt.cls == keypad_pkg::KEY_ENTER);

  // Entry is offered for as long as we sit in PRESENT
  assign entry_valid = (state == PRESENT);
  assign xfer        = entry_valid && entry_ready;

  always_comb begin
    state_next = state;
    acc_push   = 1'b0;
    acc_clear  = 1'b0;
    case (state)
      COLLECT: begin
        // Letter keys and ghosts arrive as KEY_NONE and fall through
        acc_push  = is_digit;
        acc_clear = is_clear;
        if (is_enter)
          state_next = PRESENT;
      end
      PRESENT: begin
        // Events are dropped here, the entry stays frozen
        if (xfer) begin
          // Empty the accumulator for the next entry
          acc_clear  = 1'b1;
          state_next = COLLECT;
        end
      end
      default: begin
        state_next = COLLECT;
      end
    endcase
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      state <= COLLECT;
    else
      state <= state_next;
  end

endmodule

//--- src/digit_accumulator.sv
module digit_accumulator (
  input  logic                                clk,
  input  logic                                nRst,
  input  logic                                acc_clear,
  input  logic                                acc_push,
  input  logic [keypad_pkg::DIGIT_W-1:0]      push_digit,
  output keypad_pkg::entry_t                  acc_entry
);

  localparam int DIGITS_W = keypad_pkg::MAX_DIGITS * keypad_pkg::DIGIT_W;

  logic full;

  // Further digits are dropped here, control never checks this
  assign full = (acc_entry.count == keypad_pkg::COUNT_W'(keypad_pkg::MAX_DIGITS));

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      acc_entry.digits <= '0;
      acc_entry.count  <= '0;
    end else if (acc_clear) begin
      // Clear wins over a push in the same cycle
      acc_entry.digits <= '0;
      acc_entry.count  <= '0;
    end else if (acc_push && !full) begin
      // New digit enters at the low nibble, older ones move up
      acc_entry.digits <= {acc_entry.digits[DIGITS_W-keypad_pkg::DIGIT_W-1:0], push_digit};
      acc_entry.count  <= acc_entry.count + 1'b1;
    end
  end

endmodule

//--- keypad/key_decoder.sv
module key_decoder (
  input  logic                  clk,
  input  logic                  nRst,
  input  keypad_pkg::key_raw_t  key_raw,
  input  logic                  key_strobe,
  output keypad_pkg::key_evt_t  key_evt,
  output logic                  key_evt_valid
);

  // Bit 2 flags a clean one-hot code, bits 1:0 give the index from the MSB
  function automatic logic [2:0] onehot_to_idx(input logic [3:0] vec);
    case (vec)
      4'b1000: onehot_to_idx = 3'b100;
      4'b0100: onehot_to_idx = 3'b101;
      4'b0010: onehot_to_idx = 3'b110;
      4'b0001: onehot_to_idx = 3'b111;
      default: onehot_to_idx = 3'b000;
    endcase
  endfunction

  logic [2:0]           row_dec;
  logic [2:0]           col_dec;
  keypad_pkg::key_evt_t evt_next;

  always_comb begin
    row_dec        = onehot_to_idx(key_raw.row);
    col_dec        = onehot_to_idx(key_raw.col);
    evt_next.cls   = keypad_pkg::KEY_NONE;
    evt_next.value = '0;
    // Ghosts fail the one-hot test, column 3 holds the letters
    if (row_dec[2] && col_dec[2] && col_dec[1:0] != 2'd3) begin
      if (row_dec[1:0] == 2'd3) begin
        // Bottom row is * 0 #
        case (col_dec[1:0])
          2'd0:    evt_next.cls = keypad_pkg::KEY_CLEAR;
          2'd1:    evt_next.cls = keypad_pkg::KEY_DIGIT;
          default: evt_next.cls = keypad_pkg::KEY_ENTER;
        endcase
      end else begin
        // Rows 0 to 2 hold 1..9 in reading order
        evt_next.cls   = keypad_pkg::KEY_DIGIT;
        evt_next.value = {2'b00, row_dec[1:0]} * 4'd3 + {2'b00, col_dec[1:0]} + 4'd1;
      end
    end
  end

  // Event payload
  always_ff @(posedge clk) begin
    if (key_strobe)
      key_evt <= evt_next;
  end

  // One-cycle valid behind the strobe
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst)
      key_evt_valid <= 1'b0;
    else
      key_evt_valid <= key_strobe;
  end

endmodule

//--- keypad/keypad_scanner.sv
module keypad_scanner (
  input  logic                             clk,
  input  logic                             nRst,
  input  logic                             enable,
  input  logic [keypad_pkg::NUM_ROWS-1:0]  read_row,
  output logic [keypad_pkg::NUM_COLS-1:0]  scan_col,
  output keypad_pkg::key_raw_t             key_raw,
  output logic                             key_strobe
);

  // Two synchronizer stages plus a delay stage for edge detection
  logic [keypad_pkg::NUM_ROWS-1:0] row_q0;
  logic [keypad_pkg::NUM_ROWS-1:0] row_q1;
  logic [keypad_pkg::NUM_ROWS-1:0] row_q1_dly;
  logic [keypad_pkg::NUM_COLS-1:0] scan_col_next;
  // High one cycle ahead of key_strobe
  logic                            row_rise_early;

  // Column selection
  always_comb begin
    scan_col_next = scan_col;
    // Freeze on the raw row so the pressed column stays driven
    if (!(|read_row) && enable) begin
      if (scan_col == '0)
        scan_col_next = {1'b1, {(keypad_pkg::NUM_COLS-1){1'b0}}};
      else
        // Walk the one-hot bit right, wrap back to the MSB
        scan_col_next = {scan_col[0], scan_col[keypad_pkg::NUM_COLS-1:1]};
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      row_q0     <= '0;
      row_q1     <= '0;
      row_q1_dly <= '0;
      scan_col   <= '0;
    end else begin
      row_q0     <= read_row;
      row_q1     <= row_q0;
      row_q1_dly <= row_q1;
      scan_col   <= scan_col_next;
    end
  end

  // Rising row bit on the second stage, one pulse per press
  assign key_strobe = |(row_q1 & ~row_q1_dly);

  // Same edge one stage earlier, used to load the key code
  assign row_rise_early = |(row_q0 & ~row_q1);

  // Capture lands on the edge that raises key_strobe
  // so the code is valid for the whole strobe cycle
  always_ff @(posedge clk) begin
    if (row_rise_early) begin
      key_raw.row <= row_q0;
      key_raw.col <= scan_col;
    end
  end

endmodule

//--- common/keypad_pkg.sv
package keypad_pkg;

  // Keypad matrix dimensions
  localparam int NUM_ROWS = 4;
  localparam int NUM_COLS = 4;

  // Entry sizing
  localparam int MAX_DIGITS = 4;
  localparam int DIGIT_W    = 4;
  // Wide enough to hold MAX_DIGITS itself
  localparam int COUNT_W    = 3;

  // Class of a decoded key press
  typedef enum logic [1:0] {
    // Letter key or ghost press
    KEY_NONE  = 2'd0,
    KEY_DIGIT = 2'd1,
    // The * key
    KEY_CLEAR = 2'd2,
    // The # key
    KEY_ENTER = 2'd3
  } key_class_e;

  // Raw key code as seen on the matrix
  // Row bit 3 is the top row, column bit 3 the leftmost column
  typedef struct packed {
    logic [NUM_ROWS-1:0] row;
    logic [NUM_COLS-1:0] col;
  } key_raw_t;

  // Decoded key event
  typedef struct packed {
    key_class_e         cls;
    // Only meaningful for KEY_DIGIT
    logic [DIGIT_W-1:0] value;
  } key_evt_t;

  // Entry being typed or presented
  // Most recent digit sits in the low nibble
  typedef struct packed {
    logic [MAX_DIGITS*DIGIT_W-1:0] digits;
    logic [COUNT_W-1:0]            count;
  } entry_t;

endpackage
